// ==== Makefile ====
LOG = sim.log

help:
	@echo "make test   build with Verilator, run the testbench, log in $(LOG)"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_ecc_codec -Mdir obj_dir -f all.f
	./obj_dir/Vtb_ecc_codec > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// ==== all.f ====
hdl/ecc_pkg.sv
hdl/ecc_lane.sv
hdl/ecc_dispatch.sv
hdl/ecc_collect.sv
hdl/ecc_codec_top.sv
testbench/tb_ecc_codec.sv

// ==== hdl/ecc_codec_top.sv ====
// Top of the four-lane Hamming(7,4) codec, dispatcher feeding parallel lanes into the collector
`timescale 1ns/1ps
`default_nettype none

module ecc_codec_top (
    input  wire logic               t_clk,
    input  wire logic               t_rst,
    input  wire logic               i_req_valid,
    input  wire ecc_pkg::ecc_req_t  i_req,
    input  wire logic               i_rsp_credit,
    output logic                    o_in_credit,
    output logic                    o_rsp_valid,
    output ecc_pkg::ecc_rsp_t       o_rsp
);
    import ecc_pkg::*;

    lane_in_t [N_LANES-1:0]   lane_in;
    lane_out_t [N_LANES-1:0]  lane_out;
    logic                     pop;

    ecc_dispatch u_dispatch (
        .t_clk       (t_clk),
        .t_rst       (t_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_pop       (pop),
        .o_in_credit (o_in_credit),
        .o_lane_in   (lane_in)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        ecc_lane u_lane (
            .t_clk (t_clk),
            .t_rst (t_rst),
            .i_in  (lane_in[g]),
            .o_out (lane_out[g])
        );
    end

    ecc_collect u_collect (
        .t_clk        (t_clk),
        .t_rst        (t_rst),
        .i_lane_out   (lane_out),
        .i_rsp_credit (i_rsp_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .o_pop        (pop)
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_collect.sv ====
// Response side of the codec, gathers lane results into a FIFO and releases them on sink credit
`timescale 1ns/1ps
`default_nettype none

module ecc_collect (
    input  wire logic                                    t_clk,
    input  wire logic                                    t_rst,
    input  wire ecc_pkg::lane_out_t [ecc_pkg::N_LANES-1:0] i_lane_out,
    input  wire logic                                    i_rsp_credit,
    output logic                                         o_rsp_valid,
    output ecc_pkg::ecc_rsp_t                            o_rsp,
    output logic                                         o_pop
);
    import ecc_pkg::*;

    logic [N_LANES-1:0]   lane_valid;
    ecc_rsp_t             rsp_in;
    logic                 wr_en;
    logic                 pop;
    logic                 fifo_full;

    ecc_rsp_t             mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]   wr_ptr;
    logic [FIFO_AW-1:0]   rd_ptr;
    logic [CREDIT_W-1:0]  count;
    logic [SINK_W-1:0]    sink_cnt;

    // Reassemble the four lanes into one response
    always_comb begin
        rsp_in.mode = i_lane_out[0].mode;
        rsp_in.payload = '0;
        rsp_in.err_mask = '0;
        for (int i = 0; i < N_LANES; i++) begin
            lane_valid[i] = i_lane_out[i].valid;
            rsp_in.err_mask[i] = i_lane_out[i].err;
            if (rsp_in.mode == MODE_ENCODE) begin
                rsp_in.payload.cw[i] = i_lane_out[i].word;
            end else begin
                rsp_in.payload.plain.data[i] = i_lane_out[i].word[DATA_W-1:0];
            end
        end
    end

    assign wr_en = lane_valid[0];
    assign fifo_full = (count == CREDIT_W'(FIFO_DEPTH));

    // Release the head once the sink has room
    assign pop = (count != '0) && (sink_cnt != '0);

    always_ff @(posedge t_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rsp_in;
        end
    end

    always_ff @(posedge t_clk or posedge t_rst) begin
        if (t_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            sink_cnt <= SINK_W'(SINK_CREDITS);
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({i_rsp_credit, pop})
                2'b10:   sink_cnt <= sink_cnt + 1'b1;
                2'b01:   sink_cnt <= sink_cnt - 1'b1;
                default: sink_cnt <= sink_cnt;
            endcase
        end
    end

    assign o_rsp_valid = pop;
    assign o_rsp = pop ? mem[rd_ptr] : '0;
    assign o_pop = pop;

    // Lanes run in lockstep
    a_lanes_agree: assert property (
        @(posedge t_clk) disable iff (t_rst)
        (lane_valid == '0) || (lane_valid == '1)
    );

    // Upstream credits bound the occupancy
    a_no_write_full: assert property (
        @(posedge t_clk) disable iff (t_rst)
        wr_en |-> !fifo_full
    );

    // Sink returns no more credits than it was given
    a_sink_bound: assert property (
        @(posedge t_clk) disable iff (t_rst)
        sink_cnt <= SINK_W'(SINK_CREDITS)
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_dispatch.sv ====
// Request side of the codec, grants upstream credits and slices requests into lane words
`timescale 1ns/1ps
`default_nettype none

module ecc_dispatch (
    input  wire logic                                    t_clk,
    input  wire logic                                    t_rst,
    input  wire logic                                    i_req_valid,
    input  wire ecc_pkg::ecc_req_t                       i_req,
    input  wire logic                                    i_pop,
    output logic                                         o_in_credit,
    output ecc_pkg::lane_in_t [ecc_pkg::N_LANES-1:0]     o_lane_in
);
    import ecc_pkg::*;

    logic [CREDIT_W-1:0]  init_cnt;
    logic                 grant_init;
    logic [CREDIT_W-1:0]  cred_cnt;
    logic                 req_valid_q;
    ecc_req_t             req_q;

    // One credit per FIFO entry right after reset
    assign grant_init = (init_cnt < CREDIT_W'(FIFO_DEPTH));

    always_ff @(posedge t_clk or posedge t_rst) begin
        if (t_rst) begin
            init_cnt <= '0;
            o_in_credit <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            if (grant_init) begin
                init_cnt <= init_cnt + 1'b1;
            end
            // A freed FIFO entry becomes a credit the next cycle
            o_in_credit <= grant_init || i_pop;
            req_valid_q <= i_req_valid;
        end
    end

    always_ff @(posedge t_clk) begin
        req_q <= i_req;
    end

    // Credits currently held by the sender
    always_ff @(posedge t_clk or posedge t_rst) begin
        if (t_rst) begin
            cred_cnt <= '0;
        end else begin
            case ({o_in_credit, i_req_valid})
                2'b10:   cred_cnt <= cred_cnt + 1'b1;
                2'b01:   cred_cnt <= cred_cnt - 1'b1;
                default: cred_cnt <= cred_cnt;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            o_lane_in[i].valid = req_valid_q;
            o_lane_in[i].mode = req_q.mode;
            if (req_q.mode == MODE_ENCODE) begin
                o_lane_in[i].word = {{(CW_W - DATA_W){1'b0}}, req_q.payload.plain.data[i]};
            end else begin
                o_lane_in[i].word = req_q.payload.cw[i];
            end
        end
    end

    // Sender must hold a credit for every request
    a_req_has_credit: assert property (
        @(posedge t_clk) disable iff (t_rst)
        i_req_valid |-> (cred_cnt != '0)
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_lane.sv ====
// Pipelined Hamming(7,4) lane instantiated once per nibble by the codec top to encode or decode
`timescale 1ns/1ps
`default_nettype none

module ecc_lane (
    input  wire logic               t_clk,
    input  wire logic               t_rst,
    input  wire ecc_pkg::lane_in_t  i_in,
    output ecc_pkg::lane_out_t      o_out
);
    import ecc_pkg::*;

    // Stage 1
    logic             s1_valid;
    ecc_mode_e        s1_mode;
    logic [CW_W-1:0]  s1_word;

    // Stage 2
    logic             s2_valid;
    ecc_mode_e        s2_mode;
    logic [CW_W-1:0]  s2_word;
    logic [2:0]       s2_par;
    logic [2:0]       s2_part;

    // Stage 3 inputs
    logic [2:0]       syndrome;
    logic [CW_W-1:0]  flip;
    logic [CW_W-1:0]  fixed;

    // Stage 3
    logic               s3_valid;
    ecc_mode_e          s3_mode;
    logic [CW_W-1:0]    s3_cw;
    logic [DATA_W-1:0]  s3_data;
    logic               s3_err;

    // Output stage
    logic             out_valid;
    ecc_mode_e        out_mode;
    logic [CW_W-1:0]  out_word;
    logic             out_err;

    always_ff @(posedge t_clk or posedge t_rst) begin
        if (t_rst) begin
            s1_valid <= 1'b0;
            s1_mode <= MODE_DECODE;
            s2_valid <= 1'b0;
            s2_mode <= MODE_DECODE;
            s3_valid <= 1'b0;
            s3_mode <= MODE_DECODE;
            out_valid <= 1'b0;
            out_mode <= MODE_DECODE;
        end else begin
            s1_valid <= i_in.valid;
            s1_mode <= i_in.mode;
            s2_valid <= s1_valid;
            s2_mode <= s1_mode;
            s3_valid <= s2_valid;
            s3_mode <= s2_mode;
            out_valid <= s3_valid;
            out_mode <= s3_mode;
        end
    end

    always_ff @(posedge t_clk) begin
        s1_word <= i_in.word;

        // Parity over the data nibble for encode
        s2_word <= s1_word;
        s2_par[0] <= s1_word[0] ^ s1_word[1] ^ s1_word[3];
        s2_par[1] <= s1_word[0] ^ s1_word[2] ^ s1_word[3];
        s2_par[2] <= s1_word[1] ^ s1_word[2] ^ s1_word[3];

        // First half of the syndrome for decode
        s2_part[0] <= s1_word[0] ^ s1_word[2];
        s2_part[1] <= s1_word[1] ^ s1_word[2];
        s2_part[2] <= s1_word[3] ^ s1_word[4];
    end

    // Finish the syndrome and flip the bit it points at
    always_comb begin
        syndrome[0] = s2_part[0] ^ s2_word[4] ^ s2_word[6];
        syndrome[1] = s2_part[1] ^ s2_word[5] ^ s2_word[6];
        syndrome[2] = s2_part[2] ^ s2_word[5] ^ s2_word[6];
        flip = '0;
        if (syndrome != 3'd0) begin
            flip[syndrome - 3'd1] = 1'b1;
        end
        fixed = s2_word ^ flip;
    end

    always_ff @(posedge t_clk) begin
        // Positions 1, 2 and 4 carry parity
        s3_cw <= {s2_word[3], s2_word[2], s2_word[1], s2_par[2],
                  s2_word[0], s2_par[1], s2_par[0]};
        s3_data <= {fixed[6], fixed[5], fixed[4], fixed[2]};
        s3_err <= (s2_mode == MODE_DECODE) && (syndrome != 3'd0);

        if (s3_mode == MODE_ENCODE) begin
            out_word <= s3_cw;
        end else begin
            out_word <= {{(CW_W - DATA_W){1'b0}}, s3_data};
        end
        out_err <= s3_err;
    end

    assign o_out = '{valid: out_valid, mode: out_mode, word: out_word, err: out_err};

    // Error flag stays aligned with the mode through the stages
    a_no_err_encode: assert property (
        @(posedge t_clk) disable iff (t_rst)
        (o_out.valid && o_out.mode == MODE_ENCODE) |-> !o_out.err
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_pkg.sv ====
// Shared widths, depths and request/response types for the four-lane Hamming(7,4) codec
`default_nettype none

package ecc_pkg;

    // Lane geometry
    localparam int N_LANES = 4;
    localparam int DATA_W = 4;
    localparam int CW_W = 7;
    localparam int PAD_W = N_LANES * (CW_W - DATA_W);

    // Buffering and flow control
    localparam int FIFO_DEPTH = 4;
    localparam int SINK_CREDITS = 2;
    localparam int LANE_LAT = 4;

    // Counter and pointer widths
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int SINK_W = $clog2(SINK_CREDITS + 1);

    typedef enum logic {
        MODE_DECODE = 1'b0,
        MODE_ENCODE = 1'b1
    } ecc_mode_e;

    // Plain data view, lane 0 in the low nibble
    typedef struct packed {
        logic [PAD_W-1:0]                pad;
        logic [N_LANES-1:0][DATA_W-1:0]  data;
    } ecc_plain_t;

    // Codewords or plain data, chosen by the mode
    typedef union packed {
        logic [N_LANES-1:0][CW_W-1:0]  cw;
        ecc_plain_t                    plain;
    } ecc_payload_u;

    typedef struct packed {
        ecc_mode_e     mode;
        ecc_payload_u  payload;
    } ecc_req_t;

    typedef struct packed {
        ecc_mode_e           mode;
        ecc_payload_u        payload;
        logic [N_LANES-1:0]  err_mask;
    } ecc_rsp_t;

    typedef struct packed {
        logic             valid;
        ecc_mode_e        mode;
        logic [CW_W-1:0]  word;
    } lane_in_t;

    typedef struct packed {
        logic             valid;
        ecc_mode_e        mode;
        logic [CW_W-1:0]  word;
        logic             err;
    } lane_out_t;

endpackage

`default_nettype wire

// ==== testbench/tb_ecc_codec.sv ====
// Testbench for the four-lane Hamming(7,4) codec that runs as the simulation top from the file list
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_codec;
    import ecc_pkg::*;

    localparam int KIND_ENCODE = 0;
    localparam int KIND_CLEAN = 1;
    localparam int KIND_FLIP = 2;
    localparam int KIND_MIX = 3;
    localparam int N_BASIC = 20;
    localparam int N_BP = 40;
    localparam int MAX_GAP = 15;
    localparam int N_REQ_TOTAL = 3 * N_BASIC + N_BP;
    // Each request needs the minimum latency plus at most one sink credit gap
    localparam int TIMEOUT_CYCLES = N_REQ_TOTAL * (LANE_LAT + 2 + MAX_GAP) + 200;

    logic      t_clk;
    logic      t_rst;
    logic      i_req_valid;
    ecc_req_t  i_req;
    logic      i_rsp_credit;
    logic      o_in_credit;
    logic      o_rsp_valid;
    ecc_rsp_t  o_rsp;

    ecc_rsp_t     exp_q[$];
    logic [31:0]  lfsr;
    int           up_credits;
    int           sink_held;
    int           owed;
    int           gap_left;
    int           gap_max;
    int           errors;
    int           tests_run;
    int           tests_passed;
    int           cycles;

    ecc_codec_top i_dut (
        .t_clk        (t_clk),
        .t_rst        (t_rst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_rsp_credit (i_rsp_credit),
        .o_in_credit  (o_in_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp)
    );

    initial begin
        t_clk = 1'b0;
        forever #5 t_clk = ~t_clk;
    end

    // Taps 32, 22, 2 and 1 with one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Bit k of the codeword is Hamming position k+1
    function automatic logic [6:0] hamming_encode(input logic [3:0] d);
        logic [6:0] cw;
        cw[2] = d[0];
        cw[4] = d[1];
        cw[5] = d[2];
        cw[6] = d[3];
        cw[0] = cw[2] ^ cw[4] ^ cw[6];
        cw[1] = cw[2] ^ cw[5] ^ cw[6];
        cw[3] = cw[4] ^ cw[5] ^ cw[6];
        return cw;
    endfunction

    task automatic build_request(input int kind, output ecc_req_t req, output ecc_rsp_t exp);
        logic [31:0]  bits;
        logic [15:0]  data;
        logic [3:0]   mask;
        logic [6:0]   lane_cw;
        int           pick;
        int           pos;
        bits = rand_bits(16);
        data = bits[15:0];
        pick = kind;
        if (kind == KIND_MIX) begin
            bits = rand_bits(2);
            pick = int'(bits[1:0]) % 3;
        end
        req = '0;
        exp = '0;
        if (pick == KIND_ENCODE) begin
            req.mode = MODE_ENCODE;
            req.payload.plain.data = data;
            exp.mode = MODE_ENCODE;
            for (int i = 0; i < N_LANES; i++) begin
                exp.payload.cw[i] = hamming_encode(data[4*i +: 4]);
            end
        end else begin
            req.mode = MODE_DECODE;
            exp.mode = MODE_DECODE;
            exp.payload.plain.data = data;
            mask = '0;
            if (pick == KIND_FLIP) begin
                bits = rand_bits(4);
                mask = (bits[3:0] == 4'd0) ? 4'd1 : bits[3:0];
            end
            for (int i = 0; i < N_LANES; i++) begin
                lane_cw = hamming_encode(data[4*i +: 4]);
                if (mask[i]) begin
                    bits = rand_bits(3);
                    pos = int'(bits[2:0]) % 7;
                    lane_cw = lane_cw ^ (7'd1 << pos);
                end
                req.payload.cw[i] = lane_cw;
            end
            exp.err_mask = mask;
        end
    endtask

    // Called at the falling edge where every DUT output is settled
    task automatic sample_outputs();
        ecc_rsp_t exp;
        if (o_in_credit) begin
            up_credits++;
        end
        if (o_rsp_valid) begin
            assert (sink_held > 0) else begin
                $display("o_rsp_valid was raised while the sink held no credit");
                errors++;
            end
            assert (exp_q.size() != 0) else begin
                $display("A response arrived with no request outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                assert (o_rsp == exp) else begin
                    $display("MISMATCH o_rsp: got %h expected %h", o_rsp, exp);
                    errors++;
                end
            end
            sink_held--;
            owed++;
        end
        if (i_rsp_credit) begin
            sink_held++;
        end
        // Credits only come back through pops, so a full FIFO stops them
        assert (up_credits + exp_q.size() <= FIFO_DEPTH) else begin
            $display("Upstream credits exceed the free FIFO entries");
            errors++;
        end
    endtask

    task automatic return_sink_credit();
        logic [31:0] bits;
        if (owed > 0 && gap_left == 0) begin
            bits = rand_bits(4);
            i_rsp_credit <= 1'b1;
            owed--;
            gap_left = int'(bits[3:0]) % (gap_max + 1);
        end else begin
            i_rsp_credit <= 1'b0;
            if (gap_left > 0) begin
                gap_left--;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic check_reset_phase();
        int errs_before;
        errs_before = errors;
        repeat (FIFO_DEPTH + 4) begin
            @(negedge t_clk);
            assert (!o_rsp_valid) else begin
                $display("MISMATCH o_rsp_valid: got %h expected %h after reset",
                         o_rsp_valid, 1'b0);
                errors++;
            end
            assert (o_rsp == '0) else begin
                $display("MISMATCH o_rsp: got %h expected %h after reset", o_rsp, 33'h0);
                errors++;
            end
            sample_outputs();
        end
        assert (up_credits == FIFO_DEPTH) else begin
            $display("MISMATCH o_in_credit pulses: got %h expected %h", up_credits, FIFO_DEPTH);
            errors++;
        end
        report_test("reset_credits", errs_before);
    endtask

    task automatic run_test(input string name, input int kind, input int n, input int gap);
        ecc_req_t  req;
        ecc_rsp_t  exp;
        int        sent;
        int        errs_before;
        sent = 0;
        errs_before = errors;
        gap_max = gap;
        while (sent < n || exp_q.size() != 0 || owed != 0) begin
            @(negedge t_clk);
            sample_outputs();
            @(posedge t_clk);
            if (sent < n && up_credits > 0) begin
                build_request(kind, req, exp);
                i_req_valid <= 1'b1;
                i_req <= req;
                exp_q.push_back(exp);
                up_credits--;
                sent++;
            end else begin
                i_req_valid <= 1'b0;
            end
            return_sink_credit();
        end
        report_test(name, errs_before);
    endtask

    always @(posedge t_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        t_rst = 1'b1;
        i_req_valid = 1'b0;
        i_req = '0;
        i_rsp_credit = 1'b0;
        lfsr = 32'hf6c0;
        up_credits = 0;
        sink_held = SINK_CREDITS;
        owed = 0;
        gap_left = 0;
        gap_max = 0;
        errors = 0;
        tests_run = 0;
        tests_passed = 0;
        cycles = 0;
        repeat (2) @(posedge t_clk);
        t_rst <= 1'b0;

        check_reset_phase();
        run_test("encode", KIND_ENCODE, N_BASIC, 0);
        run_test("decode_clean", KIND_CLEAN, N_BASIC, 1);
        run_test("decode_flip", KIND_FLIP, N_BASIC, 1);
        run_test("backpressure", KIND_MIX, N_BP, MAX_GAP);

        $display("Summary: %0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
